// File: Bender.yml
package:
  name: tsc_backend

sources:
  - design/tsc_pkg.sv
  - design/alu_unit.sv
  - design/execute_stage.sv
  - design/ex_mem_reg.sv
  - design/mem_stage.sv
  - design/tsc_backend.sv
  - target: test
    files:
      - verif/tsc_backend_tb.sv

// File: design/alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
    input  tsc_pkg::alu_op_e                  alu_op,
    input  logic [1:0]                        br_code,
    input  logic [tsc_pkg::word_size-1:0]     a,
    input  logic [tsc_pkg::word_size-1:0]     b,
    output logic [tsc_pkg::word_size-1:0]     result,
    output logic                              b_cond
);

    import tsc_pkg::*;

    always_comb begin
        case (alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_orr: result = a | b;
            alu_not: result = ~a;
            alu_tcp: result = ~a + word_size'(1);   // two's complement of a
            alu_shl: result = a << 1;
            alu_shr: result = a >> 1;               // logical
            default: result = '0;
        endcase
    end

    // branch condition, code is the opcode low bits
    always_comb begin
        case (br_code)
            op_bne[1:0]: b_cond = (a != b);
            op_beq[1:0]: b_cond = (a == b);
            op_bgz[1:0]: b_cond = ($signed(a) > 0);
            op_blz[1:0]: b_cond = ($signed(a) < 0);
            default:     b_cond = 1'b0;
        endcase
    end

endmodule

// File: design/ex_mem_reg.sv
`timescale 1ns/100ps

module ex_mem_reg (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              ex_valid,
    input  logic [tsc_pkg::word_size-1:0]     target_address,
    input  logic                              b_cond,
    input  logic [tsc_pkg::word_size-1:0]     alu_result,
    input  logic [tsc_pkg::word_size-1:0]     r_data2,
    input  logic [1:0]                        rd,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  logic                              b_op,
    input  logic                              reg_write,
    input  logic                              mem_to_reg,
    output logic                              valid_q,
    output logic [tsc_pkg::word_size-1:0]     target_address_q,
    output logic                              b_cond_q,
    output logic [tsc_pkg::word_size-1:0]     alu_result_q,
    output logic [tsc_pkg::word_size-1:0]     r_data2_q,
    output logic [1:0]                        rd_q,
    output logic                              mem_read_q,
    output logic                              mem_write_q,
    output logic                              b_op_q,
    output logic                              reg_write_q,
    output logic                              mem_to_reg_q
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q          <= 1'b0;
            target_address_q <= '0;
            b_cond_q         <= 1'b0;
            alu_result_q     <= '0;
            r_data2_q        <= '0;
            rd_q             <= '0;
            mem_read_q       <= 1'b0;
            mem_write_q      <= 1'b0;
            b_op_q           <= 1'b0;
            reg_write_q      <= 1'b0;
            mem_to_reg_q     <= 1'b0;
        end else begin
            valid_q          <= ex_valid;
            target_address_q <= target_address;
            alu_result_q     <= alu_result;
            r_data2_q        <= r_data2;
            rd_q             <= rd;
            // a bubble drops every control bit
            b_cond_q         <= b_cond & ex_valid;
            mem_read_q       <= mem_read & ex_valid;
            mem_write_q      <= mem_write & ex_valid;
            b_op_q           <= b_op & ex_valid;
            reg_write_q      <= reg_write & ex_valid;
            mem_to_reg_q     <= mem_to_reg & ex_valid;
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_read_q && mem_write_q))
        else $error("load and store both pending in EX/MEM");

endmodule

// File: design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                              in_valid,
    input  tsc_pkg::instr_u                   instr,
    input  logic [tsc_pkg::word_size-1:0]     pc,
    input  logic [tsc_pkg::word_size-1:0]     rs_val,
    input  logic [tsc_pkg::word_size-1:0]     rt_val,
    output logic                              ex_valid,
    output logic [tsc_pkg::word_size-1:0]     target_address,
    output logic                              b_cond,
    output logic [tsc_pkg::word_size-1:0]     alu_result,
    output logic [tsc_pkg::word_size-1:0]     r_data2,
    output logic [1:0]                        rd,
    output logic                              mem_read,
    output logic                              mem_write,
    output logic                              b_op,
    output logic                              reg_write,
    output logic                              mem_to_reg
);

    import tsc_pkg::*;

    logic [word_size-1:0] imm_sext;
    logic [word_size-1:0] imm_zext;
    logic [word_size-1:0] alu_a;
    logic [word_size-1:0] alu_b;
    alu_op_e              alu_op;

    assign imm_sext = {{(word_size-8){instr.i_fmt.imm[7]}}, instr.i_fmt.imm};
    assign imm_zext = {{(word_size-8){1'b0}}, instr.i_fmt.imm};

    assign ex_valid       = in_valid;
    assign r_data2        = rt_val;                         // store data
    assign target_address = pc + word_size'(1) + imm_sext;  // separate branch adder

    always_comb begin
        alu_op     = alu_add;
        alu_a      = rs_val;
        alu_b      = imm_sext;
        rd         = instr.i_fmt.rt;    // i-type writes rt
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        b_op       = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        case (instr.r_fmt.opcode)
            op_rtype: begin
                alu_op    = alu_op_e'(instr.r_fmt.func[2:0]);
                alu_b     = rt_val;
                rd        = instr.r_fmt.rd;
                reg_write = (instr.r_fmt.func[5:3] == 3'b000);   // unknown func is a no-op
            end
            op_adi: reg_write = 1'b1;
            op_ori: begin
                alu_op    = alu_orr;
                alu_b     = imm_zext;
                reg_write = 1'b1;
            end
            op_lhi: begin
                alu_op    = alu_orr;
                alu_a     = '0;
                alu_b     = {instr.i_fmt.imm, {(word_size-8){1'b0}}};
                reg_write = 1'b1;
            end
            op_lwd: begin
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            op_swd: mem_write = 1'b1;
            op_bne, op_beq, op_bgz, op_blz: begin
                alu_b = rt_val;     // compare rs against rt
                b_op  = 1'b1;
            end
            default: ;
        endcase
    end

    alu_unit u_alu (
        .alu_op  (alu_op),
        .br_code (instr.r_fmt.opcode[1:0]),
        .a       (alu_a),
        .b       (alu_b),
        .result  (alu_result),
        .b_cond  (b_cond)
    );

endmodule

// File: design/mem_stage.sv
`timescale 1ns/100ps

module mem_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              valid_q,
    input  logic [tsc_pkg::word_size-1:0]     alu_result_q,
    input  logic [tsc_pkg::word_size-1:0]     r_data2_q,
    input  logic [1:0]                        rd_q,
    input  logic                              mem_read_q,
    input  logic                              mem_write_q,
    input  logic                              reg_write_q,
    input  logic                              mem_to_reg_q,
    output logic                              wb_en,
    output logic [1:0]                        wb_rd,
    output logic [tsc_pkg::word_size-1:0]     wb_data
);

    import tsc_pkg::*;

    logic [word_size-1:0]         mem [mem_depth];
    logic [$clog2(mem_depth)-1:0] mem_addr;
    logic [word_size-1:0]         load_data;
    logic [word_size-1:0]         wb_next;

    assign mem_addr = alu_result_q[$clog2(mem_depth)-1:0];   // upper address bits ignored

    // store lands at the edge that ends the EX/MEM cycle
    always_ff @(posedge clk) begin
        if (valid_q && mem_write_q) begin
            mem[mem_addr] <= r_data2_q;
        end
    end

    // async read, so a load right behind a store sees the new word
    assign load_data = mem_read_q ? mem[mem_addr] : '0;
    assign wb_next   = mem_to_reg_q ? load_data : alu_result_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en   <= 1'b0;
            wb_rd   <= '0;
            wb_data <= '0;
        end else begin
            wb_en   <= valid_q & reg_write_q;
            wb_rd   <= rd_q;
            wb_data <= wb_next;
        end
    end

    a_load_wb: assert property (@(posedge clk) disable iff (!arst_n)
        (valid_q && mem_read_q) |-> (mem_to_reg_q && reg_write_q))
        else $error("load in EX/MEM without a memory writeback");

endmodule

// File: design/tsc_backend.sv
`timescale 1ns/100ps

module tsc_backend (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  tsc_pkg::instr_u                   instr,
    input  logic [tsc_pkg::word_size-1:0]     pc,
    input  logic [tsc_pkg::word_size-1:0]     rs_val,
    input  logic [tsc_pkg::word_size-1:0]     rt_val,
    output logic                              br_taken,
    output logic [tsc_pkg::word_size-1:0]     br_target,
    output logic                              wb_en,
    output logic [1:0]                        wb_rd,
    output logic [tsc_pkg::word_size-1:0]     wb_data
);

    import tsc_pkg::*;

    logic                 ex_valid;
    logic [word_size-1:0] target_address;
    logic                 b_cond;
    logic [word_size-1:0] alu_result;
    logic [word_size-1:0] r_data2;
    logic [1:0]           rd;
    logic                 mem_read;
    logic                 mem_write;
    logic                 b_op;
    logic                 reg_write;
    logic                 mem_to_reg;

    logic                 valid_q;
    logic [word_size-1:0] target_address_q;
    logic                 b_cond_q;
    logic [word_size-1:0] alu_result_q;
    logic [word_size-1:0] r_data2_q;
    logic [1:0]           rd_q;
    logic                 mem_read_q;
    logic                 mem_write_q;
    logic                 b_op_q;
    logic                 reg_write_q;
    logic                 mem_to_reg_q;

    execute_stage u_ex (
        .in_valid       (in_valid),
        .instr          (instr),
        .pc             (pc),
        .rs_val         (rs_val),
        .rt_val         (rt_val),
        .ex_valid       (ex_valid),
        .target_address (target_address),
        .b_cond         (b_cond),
        .alu_result     (alu_result),
        .r_data2        (r_data2),
        .rd             (rd),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .b_op           (b_op),
        .reg_write      (reg_write),
        .mem_to_reg     (mem_to_reg)
    );

    ex_mem_reg u_ex_mem (
        .clk              (clk),
        .arst_n           (arst_n),
        .ex_valid         (ex_valid),
        .target_address   (target_address),
        .b_cond           (b_cond),
        .alu_result       (alu_result),
        .r_data2          (r_data2),
        .rd               (rd),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .b_op             (b_op),
        .reg_write        (reg_write),
        .mem_to_reg       (mem_to_reg),
        .valid_q          (valid_q),
        .target_address_q (target_address_q),
        .b_cond_q         (b_cond_q),
        .alu_result_q     (alu_result_q),
        .r_data2_q        (r_data2_q),
        .rd_q             (rd_q),
        .mem_read_q       (mem_read_q),
        .mem_write_q      (mem_write_q),
        .b_op_q           (b_op_q),
        .reg_write_q      (reg_write_q),
        .mem_to_reg_q     (mem_to_reg_q)
    );

    mem_stage u_mem (
        .clk          (clk),
        .arst_n       (arst_n),
        .valid_q      (valid_q),
        .alu_result_q (alu_result_q),
        .r_data2_q    (r_data2_q),
        .rd_q         (rd_q),
        .mem_read_q   (mem_read_q),
        .mem_write_q  (mem_write_q),
        .reg_write_q  (reg_write_q),
        .mem_to_reg_q (mem_to_reg_q),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    // redirect comes straight out of EX/MEM
    assign br_taken  = b_op_q & b_cond_q & valid_q;
    assign br_target = target_address_q;

endmodule

// File: design/tsc_pkg.sv
package tsc_pkg;

    localparam int word_size = 16;
    localparam int mem_depth = 256;     // indexed by low address bits

    // i-type opcodes
    localparam logic [3:0] op_adi = 4'd4;
    localparam logic [3:0] op_ori = 4'd5;
    localparam logic [3:0] op_lhi = 4'd6;
    localparam logic [3:0] op_lwd = 4'd7;
    localparam logic [3:0] op_swd = 4'd8;

    // branches, low two bits pick the condition
    localparam logic [3:0] op_bne = 4'd0;
    localparam logic [3:0] op_beq = 4'd1;
    localparam logic [3:0] op_bgz = 4'd2;
    localparam logic [3:0] op_blz = 4'd3;

    localparam logic [3:0] op_rtype = 4'd15;

    // r-type function field
    localparam logic [5:0] fn_add = 6'd0;
    localparam logic [5:0] fn_sub = 6'd1;
    localparam logic [5:0] fn_and = 6'd2;
    localparam logic [5:0] fn_orr = 6'd3;
    localparam logic [5:0] fn_not = 6'd4;
    localparam logic [5:0] fn_tcp = 6'd5;
    localparam logic [5:0] fn_shl = 6'd6;
    localparam logic [5:0] fn_shr = 6'd7;

    typedef enum logic [2:0] {
        alu_add = 3'(fn_add),
        alu_sub = 3'(fn_sub),
        alu_and = 3'(fn_and),
        alu_orr = 3'(fn_orr),
        alu_not = 3'(fn_not),
        alu_tcp = 3'(fn_tcp),
        alu_shl = 3'(fn_shl),
        alu_shr = 3'(fn_shr)
    } alu_op_e;

    // same 16 bits, two views
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rs;
            logic [1:0] rt;
            logic [1:0] rd;
            logic [5:0] func;
        } r_fmt;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rs;
            logic [1:0] rt;
            logic [7:0] imm;
        } i_fmt;
    } instr_u;

endpackage

// File: tsc_backend.f
design/tsc_pkg.sv
design/alu_unit.sv
design/execute_stage.sv
design/ex_mem_reg.sv
design/mem_stage.sv
design/tsc_backend.sv
verif/tsc_backend_tb.sv

// File: verif/tsc_backend_tb.sv
`timescale 1ns/100ps

module tsc_backend_tb;

    import tsc_pkg::*;

    localparam int max_rows = 64;
    localparam int n_groups = 6;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic [15:0] instr;
    logic [15:0] pc;
    logic [15:0] rs_val;
    logic [15:0] rt_val;
    logic        br_taken;
    logic [15:0] br_target;
    logic        wb_en;
    logic [1:0]  wb_rd;
    logic [15:0] wb_data;

    // stimulus and expected values, one entry per issue slot
    int          t_group   [max_rows];
    logic        t_valid   [max_rows];
    logic [15:0] t_instr   [max_rows];
    logic [15:0] t_pc      [max_rows];
    logic [15:0] t_rs      [max_rows];
    logic [15:0] t_rt      [max_rows];
    logic        t_br      [max_rows];
    logic [15:0] t_tgt     [max_rows];
    logic        t_wb_en   [max_rows];
    logic [1:0]  t_wb_rd   [max_rows];
    logic [15:0] t_wb_data [max_rows];

    string grp_name   [n_groups];
    int    grp_errors [n_groups];
    int    n_rows;
    int    cur_group;
    int    n_checks;
    int    n_errors;

    tsc_backend dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .br_taken  (br_taken),
        .br_target (br_target),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] r_type(input int rs, input int rt, input int rd,
                                           input logic [5:0] fn);
        return {op_rtype, 2'(rs), 2'(rt), 2'(rd), fn};
    endfunction

    function automatic logic [15:0] i_type(input logic [3:0] op, input int rs, input int rt,
                                           input logic [7:0] imm);
        return {op, 2'(rs), 2'(rt), imm};
    endfunction

    task automatic add_row(input logic v, input logic [15:0] ins, input logic [15:0] p,
                           input logic [15:0] rs, input logic [15:0] rt, input logic br,
                           input logic [15:0] tgt, input logic we, input logic [1:0] wrd,
                           input logic [15:0] wdat);
        t_group[n_rows]   = cur_group;
        t_valid[n_rows]   = v;
        t_instr[n_rows]   = ins;
        t_pc[n_rows]      = p;
        t_rs[n_rows]      = rs;
        t_rt[n_rows]      = rt;
        t_br[n_rows]      = br;
        t_tgt[n_rows]     = tgt;
        t_wb_en[n_rows]   = we;
        t_wb_rd[n_rows]   = wrd;
        t_wb_data[n_rows] = wdat;
        n_rows++;
    endtask

    task automatic check_value(input string name, input int grp, input int row,
                               input logic [15:0] got, input logic [15:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            grp_errors[grp]++;
            $display("FAILED %s row %0d: got 0x%h expected 0x%h", name, row, got, exp);
        end
    endtask

    task automatic report_group(input int g);
        if (grp_errors[g] == 0)
            $display("test %s: ok", grp_name[g]);
        else
            $display("test %s: %0d mismatches", grp_name[g], grp_errors[g]);
    endtask

    task automatic check_branch(input int r);
        check_value("br_taken", t_group[r], r, br_taken, t_br[r]);
        if (t_valid[r] && t_instr[r][15:14] == 2'b00)   // opcodes 0..3 are branches
            check_value("br_target", t_group[r], r, br_target, t_tgt[r]);
    endtask

    task automatic check_writeback(input int r);
        check_value("wb_en", t_group[r], r, wb_en, t_wb_en[r]);
        if (t_wb_en[r]) begin
            check_value("wb_rd", t_group[r], r, wb_rd, t_wb_rd[r]);
            check_value("wb_data", t_group[r], r, wb_data, t_wb_data[r]);
        end
        if (r == n_rows - 1 || t_group[r + 1] != t_group[r])
            report_group(t_group[r]);
    endtask

    initial begin
        #1;
        #((n_rows + 16 + 10) * 10);
        $display("timeout: pipeline run did not complete");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int c;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        pc       = '0;
        rs_val   = '0;
        rt_val   = '0;
        n_rows   = 0;
        n_checks = 0;
        n_errors = 0;
        grp_name = '{"reset", "r-type", "immediates", "memory", "branches", "bubbles"};
        grp_errors = '{default: 0};

        cur_group = 1;
        add_row(1, r_type(0, 1, 1, fn_add), 'h0, 'h1234, 'h0F0F, 0, 'h0, 1, 1, 'h2143);
        add_row(1, r_type(0, 1, 2, fn_sub), 'h0, 'h1234, 'h0F0F, 0, 'h0, 1, 2, 'h0325);
        add_row(1, r_type(0, 1, 3, fn_and), 'h0, 'h1234, 'h0F0F, 0, 'h0, 1, 3, 'h0204);
        add_row(1, r_type(0, 1, 0, fn_orr), 'h0, 'h1234, 'h0F0F, 0, 'h0, 1, 0, 'h1F3F);
        add_row(1, r_type(0, 1, 1, fn_not), 'h0, 'h1234, 'h0F0F, 0, 'h0, 1, 1, 'hEDCB);
        add_row(1, r_type(0, 1, 2, fn_tcp), 'h0, 'h1234, 'h0F0F, 0, 'h0, 1, 2, 'hEDCC);
        add_row(1, r_type(0, 1, 3, fn_shl), 'h0, 'h8001, 'h0F0F, 0, 'h0, 1, 3, 'h0002);
        add_row(1, r_type(0, 1, 0, fn_shr), 'h0, 'h8001, 'h0F0F, 0, 'h0, 1, 0, 'h4000);

        cur_group = 2;
        add_row(1, i_type(op_adi, 0, 2, 'hF0), 'h0, 'h0100, 'h0, 0, 'h0, 1, 2, 'h00F0);
        add_row(1, i_type(op_adi, 0, 1, 'h7F), 'h0, 'h0100, 'h0, 0, 'h0, 1, 1, 'h017F);
        add_row(1, i_type(op_ori, 0, 3, 'hF0), 'h0, 'h1200, 'h0, 0, 'h0, 1, 3, 'h12F0);
        add_row(1, i_type(op_lhi, 0, 0, 'hA5), 'h0, 'hFFFF, 'h0, 0, 'h0, 1, 0, 'hA500);

        cur_group = 3;
        add_row(1, i_type(op_swd, 0, 1, 'h04), 'h0, 'h0020, 'hBEEF, 0, 'h0, 0, 0, 'h0);
        add_row(1, i_type(op_lwd, 0, 1, 'h04), 'h0, 'h0020, 'h0, 0, 'h0, 1, 1, 'hBEEF);
        add_row(1, i_type(op_swd, 0, 1, 'hFE), 'h0, 'h0030, 'h1357, 0, 'h0, 0, 0, 'h0);
        add_row(1, i_type(op_swd, 0, 1, 'h00), 'h0, 'h0040, 'h2468, 0, 'h0, 0, 0, 'h0);
        add_row(1, i_type(op_lwd, 0, 2, 'hFE), 'h0, 'h0030, 'h0, 0, 'h0, 1, 2, 'h1357);
        add_row(1, i_type(op_lwd, 0, 3, 'h00), 'h0, 'h0040, 'h0, 0, 'h0, 1, 3, 'h2468);

        cur_group = 4;
        add_row(1, i_type(op_bne, 0, 1, 'h10), 'h0100, 'h0005, 'h0006, 1, 'h0111, 0, 0, 'h0);
        add_row(1, i_type(op_bne, 0, 1, 'h10), 'h0200, 'h0005, 'h0005, 0, 'h0211, 0, 0, 'h0);
        add_row(1, i_type(op_beq, 0, 1, 'hF0), 'h0300, 'hAAAA, 'hAAAA, 1, 'h02F1, 0, 0, 'h0);
        add_row(1, i_type(op_beq, 0, 1, 'hF0), 'h0400, 'hAAAA, 'hAAAB, 0, 'h03F1, 0, 0, 'h0);
        add_row(1, i_type(op_bgz, 0, 1, 'h08), 'h0500, 'h0001, 'h0, 1, 'h0509, 0, 0, 'h0);
        add_row(1, i_type(op_bgz, 0, 1, 'h08), 'h0600, 'h0000, 'h0, 0, 'h0609, 0, 0, 'h0);
        add_row(1, i_type(op_bgz, 0, 1, 'h08), 'h0700, 'h8000, 'h0, 0, 'h0709, 0, 0, 'h0);
        add_row(1, i_type(op_blz, 0, 1, 'h80), 'h0800, 'hFFFF, 'h0, 1, 'h0781, 0, 0, 'h0);
        add_row(1, i_type(op_blz, 0, 1, 'h80), 'h0900, 'h0000, 'h0, 0, 'h0881, 0, 0, 'h0);

        cur_group = 5;
        add_row(0, i_type(op_swd, 0, 1, 'h04), 'h0, 'h0020, 'hDEAD, 0, 'h0, 0, 0, 'h0);
        add_row(0, i_type(op_adi, 0, 1, 'h01), 'h0, 'h0001, 'h0, 0, 'h0, 0, 0, 'h0);
        add_row(0, i_type(op_beq, 0, 1, 'h01), 'h0, 'h0001, 'h0001, 0, 'h0, 0, 0, 'h0);
        add_row(1, i_type(op_lwd, 0, 2, 'h04), 'h0, 'h0020, 'h0, 0, 'h0, 1, 2, 'hBEEF);

        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("br_taken", 0, 0, br_taken, 0);
        check_value("wb_en", 0, 0, wb_en, 0);
        report_group(0);

        // branch outputs trail issue by one cycle, writeback by two
        for (c = 0; c < n_rows + 2; c++) begin
            @(posedge clk);
            if (c < n_rows) begin
                in_valid <= t_valid[c];
                instr    <= t_instr[c];
                pc       <= t_pc[c];
                rs_val   <= t_rs[c];
                rt_val   <= t_rt[c];
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            if (c >= 1)
                check_branch(c - 1);
            if (c >= 2)
                check_writeback(c - 2);
        end

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
